/* rtl/band_pkg.sv */
`default_nettype none

package band_pkg;

    // widths shared by the meter and its testbench
    localparam int SAMPLE_W   = 11;
    localparam int NUM_TAPS   = 10;
    localparam int COUNT_W    = 17;
    localparam int LEVEL_W    = 11;
    localparam int BAND_IDX_W = 4;

    typedef logic signed [SAMPLE_W-1:0]   sample_t;
    typedef sample_t     [NUM_TAPS-1:0]   tap_vec_t;
    typedef logic        [COUNT_W-1:0]    count_t;
    typedef logic        [LEVEL_W-1:0]    level_t;
    typedef logic        [BAND_IDX_W-1:0] band_idx_t;

    // slot of each weighted copy inside tap_vec_t
    localparam int TAP_P050 = 0;
    localparam int TAP_P062 = 1;
    localparam int TAP_P075 = 2;
    localparam int TAP_P088 = 3;
    localparam int TAP_P100 = 4;
    localparam int TAP_N050 = 5;
    localparam int TAP_N062 = 6;
    localparam int TAP_N075 = 7;
    localparam int TAP_N088 = 8;
    localparam int TAP_N100 = 9;

endpackage

`default_nettype wire

/* rtl/tap_scaler.sv */
`timescale 1ns/1ns
`default_nettype none

module tap_scaler
    import band_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  sample_t  sample_in,
    input  logic     sample_valid,
    output tap_vec_t taps
);

    sample_t half;
    sample_t five_eighth;
    sample_t three_quarter;
    sample_t seven_eighth;

    // shift-add weights, arithmetic shift rounds toward -inf
    assign half          = sample_in >>> 1;
    assign five_eighth   = (sample_in >>> 1) + (sample_in >>> 3);
    assign three_quarter = (sample_in >>> 1) + (sample_in >>> 2);
    assign seven_eighth  = sample_in - (sample_in >>> 3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taps <= '0;
        end else if (sample_valid) begin
            taps[TAP_P050] <= half;
            taps[TAP_P062] <= five_eighth;
            taps[TAP_P075] <= three_quarter;
            taps[TAP_P088] <= seven_eighth;
            taps[TAP_P100] <= sample_in;
            // negated copies wrap at full scale like the positive ones
            taps[TAP_N050] <= -half;
            taps[TAP_N062] <= -five_eighth;
            taps[TAP_N075] <= -three_quarter;
            taps[TAP_N088] <= -seven_eighth;
            taps[TAP_N100] <= -sample_in;
        end
    end

endmodule

`default_nettype wire

/* rtl/band_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module band_detector
    import band_pkg::*;
#(
    parameter int STRIPE = 7,
    parameter int SMOOTH = 9,
    parameter int LEVEL  = 17
)
(
    input  logic     clk,
    input  logic     rst,
    input  tap_vec_t taps,
    input  count_t   band_count,
    output level_t   level
);

    localparam int FILT_W = 16;
    localparam int EMA_W  = 18;

    count_t                    step_cnt;
    logic                      step;
    logic        [4:0]         phase;
    logic        [4:0]         q_phase;
    sample_t                   i_mix;
    sample_t                   q_mix;
    logic signed [FILT_W-1:0]  i_filt;
    logic signed [FILT_W-1:0]  q_filt;
    logic        [FILT_W-1:0]  abs_i;
    logic        [FILT_W-1:0]  abs_q;
    logic        [FILT_W:0]    sum_abs;
    logic        [EMA_W-1:0]   ema;

    // stepped sine over 32 phases
    // first half picks positive weights, second half the negated ones
    function automatic sample_t ref_tap(input tap_vec_t t, input logic [4:0] ph);
        sample_t pick;
        case (ph[3:0])
            4'd0: begin
                pick = '0;
            end
            4'd1, 4'd15: begin
                pick = ph[4] ? t[TAP_N050] : t[TAP_P050];
            end
            4'd2, 4'd14: begin
                pick = ph[4] ? t[TAP_N062] : t[TAP_P062];
            end
            4'd3, 4'd13: begin
                pick = ph[4] ? t[TAP_N075] : t[TAP_P075];
            end
            4'd4, 4'd12: begin
                pick = ph[4] ? t[TAP_N088] : t[TAP_P088];
            end
            default: begin
                pick = ph[4] ? t[TAP_N100] : t[TAP_P100];
            end
        endcase
        return pick;
    endfunction

    // step pulse every band_count clocks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            step     <= 1'b0;
        end else if (step_cnt == band_count - 1'b1) begin
            step_cnt <= '0;
            step     <= 1'b1;
        end else begin
            step_cnt <= step_cnt + 1'b1;
            step     <= 1'b0;
        end
    end

    // quadrature arm runs a quarter period ahead
    assign q_phase = phase + 5'd8;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
            i_mix <= '0;
            q_mix <= '0;
        end else if (step) begin
            phase <= phase + 1'b1;
            i_mix <= ref_tap(taps, phase);
            q_mix <= ref_tap(taps, q_phase);
        end
    end

    // leaky integrators, one per arm
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            i_filt <= '0;
            q_filt <= '0;
        end else if (step) begin
            i_filt <= i_filt - (i_filt >>> STRIPE) + i_mix;
            q_filt <= q_filt - (q_filt >>> STRIPE) + q_mix;
        end
    end

    // rectifier
    assign abs_i   = i_filt[FILT_W-1] ? -i_filt : i_filt;
    assign abs_q   = q_filt[FILT_W-1] ? -q_filt : q_filt;
    assign sum_abs = abs_i + abs_q;

    // exponential average of the magnitude
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ema <= '0;
        end else if (step) begin
            ema <= ema - (ema >> SMOOTH) + (sum_abs >> SMOOTH);
        end
    end

    // output slice, updated every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level <= '0;
        end else begin
            level <= ema[LEVEL -: LEVEL_W];
        end
    end

endmodule

`default_nettype wire

/* rtl/band_config.sv */
`timescale 1ns/1ns
`default_nettype none

module band_config
    import band_pkg::*;
#(
    parameter int NUM_BANDS = 4
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cfg_we,
    input  band_idx_t                cfg_addr,
    input  count_t                   cfg_wdata,
    output count_t                   cfg_rdata,
    output count_t [NUM_BANDS-1:0]   band_counts
);

    count_t wdata_fixed;

    // zero would stall a step counter, keep it at one
    assign wdata_fixed = (cfg_wdata == '0) ? count_t'(1) : cfg_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < NUM_BANDS; b++) begin
                band_counts[b] <= count_t'(1);
            end
        end else if (cfg_we) begin
            // unmatched addresses fall through untouched
            for (int b = 0; b < NUM_BANDS; b++) begin
                if (cfg_addr == band_idx_t'(b)) begin
                    band_counts[b] <= wdata_fixed;
                end
            end
        end
    end

    // read-back, zero outside the band range
    always_comb begin
        cfg_rdata = '0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            if (cfg_addr == band_idx_t'(b)) begin
                cfg_rdata = band_counts[b];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/band_peak_finder.sv */
`timescale 1ns/1ns
`default_nettype none

module band_peak_finder
    import band_pkg::*;
#(
    parameter int NUM_BANDS = 4
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  level_t [NUM_BANDS-1:0]   levels,
    output band_idx_t                peak_band,
    output level_t                   peak_level
);

    band_idx_t best_band;
    level_t    best_level;

    // linear scan, strict compare keeps the lowest index on a tie
    always_comb begin
        best_band  = '0;
        best_level = levels[0];
        for (int b = 1; b < NUM_BANDS; b++) begin
            if (levels[b] > best_level) begin
                best_band  = band_idx_t'(b);
                best_level = levels[b];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            peak_band  <= '0;
            peak_level <= '0;
        end else begin
            peak_band  <= best_band;
            peak_level <= best_level;
        end
    end

endmodule

`default_nettype wire

/* rtl/band_meter_top.sv */
`timescale 1ns/1ns
`default_nettype none

module band_meter_top
    import band_pkg::*;
#(
    parameter int NUM_BANDS = 4,
    parameter int STRIPE    = 7,
    parameter int SMOOTH    = 9,
    parameter int LEVEL     = 17
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  sample_t                  sample_in,
    input  logic                     sample_valid,
    input  logic                     cfg_we,
    input  band_idx_t                cfg_addr,
    input  count_t                   cfg_wdata,
    output count_t                   cfg_rdata,
    output level_t [NUM_BANDS-1:0]   levels,
    output band_idx_t                peak_band,
    output level_t                   peak_level
);

    tap_vec_t                taps;
    count_t [NUM_BANDS-1:0]  band_counts;

    // weighted copies shared by every detector
    tap_scaler u_scaler (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .taps         (taps)
    );

    band_config #(
        .NUM_BANDS (NUM_BANDS)
    ) u_config (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .band_counts (band_counts)
    );

    // one detector per band
    for (genvar g = 0; g < NUM_BANDS; g++) begin : g_band
        band_detector #(
            .STRIPE (STRIPE),
            .SMOOTH (SMOOTH),
            .LEVEL  (LEVEL)
        ) u_detector (
            .clk        (clk),
            .rst        (rst),
            .taps       (taps),
            .band_count (band_counts[g]),
            .level      (levels[g])
        );
    end

    band_peak_finder #(
        .NUM_BANDS (NUM_BANDS)
    ) u_peak (
        .clk        (clk),
        .rst        (rst),
        .levels     (levels),
        .peak_band  (peak_band),
        .peak_level (peak_level)
    );

endmodule

`default_nettype wire

/* sim/band_meter_props.sv */
`timescale 1ns/1ns
`default_nettype none

module band_meter_props
    import band_pkg::*;
#(
    parameter bit IS_DETECTOR = 1'b1,
    parameter int NUM_BANDS   = 4
)
(
    input logic      clk,
    input logic      rst,
    input logic      step,
    input count_t    band_count,
    input level_t    level,
    input logic      cfg_we,
    input band_idx_t cfg_addr,
    input count_t    cfg_wdata,
    input count_t    cfg_rdata
);

    if (IS_DETECTOR) begin : g_detector
        // pulse must drop after one cycle unless the band steps every clock
        a_step_single: assert property (@(posedge clk) disable iff (rst)
            (step && band_count > count_t'(1)) |=> !step)
            else $error("step pulse lasted more than one cycle");

        a_level_reset: assert property (@(posedge clk) $fell(rst) |-> level == '0)
            else $error("level not zero right after reset");
    end else begin : g_config
        a_zero_count: assert property (@(posedge clk) disable iff (rst)
            (cfg_we && cfg_wdata == '0 && int'(cfg_addr) < NUM_BANDS)
            |=> (!$stable(cfg_addr) || cfg_rdata == count_t'(1)))
            else $error("written zero count did not read back as one");
    end

endmodule

bind band_detector band_meter_props #(.IS_DETECTOR(1'b1)) u_props (
    .clk (clk), .rst (rst), .step (step), .band_count (band_count), .level (level),
    .cfg_we (1'b0), .cfg_addr ('0), .cfg_wdata ('0), .cfg_rdata ('0)
);

bind band_config band_meter_props #(.IS_DETECTOR(1'b0), .NUM_BANDS(NUM_BANDS)) u_props (
    .clk (clk), .rst (rst), .step (1'b0), .band_count ('0), .level ('0),
    .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
);

`default_nettype wire

/* sim/band_meter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module band_meter_tb
    import band_pkg::*;
;

    localparam int NB       = 4;
    localparam int STRIPE_T = 3;
    localparam int SMOOTH_T = 2;
    localparam int LEVEL_T  = 12;
    localparam int NROWS    = 5;

    // exp_band of -1 leaves the peak to the model alone
    typedef struct {
        int counts [NB];
        int period;
        int amp;
        bit noise;
        int run;
        int exp_band;
    } row_t;

    logic                clk;
    logic                rst;
    sample_t             sample_in;
    logic                sample_valid;
    logic                cfg_we;
    band_idx_t           cfg_addr;
    count_t              cfg_wdata;
    count_t              cfg_rdata;
    level_t [NB-1:0]     levels;
    band_idx_t           peak_band;
    level_t              peak_level;

    row_t rows [NROWS];
    int   cycles;
    int   limit;

    // reference model state
    sample_t             m_sample;
    count_t              m_counts [NB];
    count_t              m_cnt [NB];
    logic                m_step [NB];
    logic [4:0]          m_phase [NB];
    sample_t             m_imix [NB];
    sample_t             m_qmix [NB];
    logic signed [15:0]  m_ifilt [NB];
    logic signed [15:0]  m_qfilt [NB];
    logic [17:0]         m_ema [NB];
    level_t              m_level [NB];
    band_idx_t           m_pband;
    level_t              m_plevel;

    band_meter_top #(
        .NUM_BANDS (NB),
        .STRIPE    (STRIPE_T),
        .SMOOTH    (SMOOTH_T),
        .LEVEL     (LEVEL_T)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .levels       (levels),
        .peak_band    (peak_band),
        .peak_level   (peak_level)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // sample times a weight in eighths using truncating shifts
    function automatic sample_t weigh(input sample_t s, input int eighths, input bit neg);
        sample_t w;
        case (eighths)
            4:       w = s >>> 1;
            5:       w = (s >>> 1) + (s >>> 3);
            6:       w = (s >>> 1) + (s >>> 2);
            7:       w = s - (s >>> 3);
            default: w = s;
        endcase
        if (neg) begin
            w = -w;
        end
        return w;
    endfunction

    // stepped sine magnitude in eighths over a half period
    function automatic sample_t ref_value(input sample_t s, input logic [4:0] ph);
        int mag [16];
        mag = '{0, 4, 5, 6, 7, 8, 8, 8, 8, 8, 8, 8, 7, 6, 5, 4};
        if (mag[ph[3:0]] == 0) begin
            return '0;
        end
        return weigh(s, mag[ph[3:0]], ph[4]);
    endfunction

    always @(posedge clk or posedge rst) begin
        int f;
        int g;
        int ai;
        int aq;
        int e;
        level_t best;
        if (rst) begin
            m_sample = '0;
            m_pband  = '0;
            m_plevel = '0;
            for (int b = 0; b < NB; b++) begin
                m_counts[b] = count_t'(1);
                m_cnt[b]    = '0;
                m_step[b]   = 1'b0;
                m_phase[b]  = '0;
                m_imix[b]   = '0;
                m_qmix[b]   = '0;
                m_ifilt[b]  = '0;
                m_qfilt[b]  = '0;
                m_ema[b]    = '0;
                m_level[b]  = '0;
            end
        end else begin
            // peak of the levels from before this edge
            best    = m_level[0];
            m_pband = '0;
            for (int b = 1; b < NB; b++) begin
                if (m_level[b] > best) begin
                    best    = m_level[b];
                    m_pband = band_idx_t'(b);
                end
            end
            m_plevel = best;
            for (int b = 0; b < NB; b++) begin
                m_level[b] = m_ema[b][LEVEL_T -: LEVEL_W];
                if (m_step[b]) begin
                    f  = int'(m_ifilt[b]);
                    g  = int'(m_qfilt[b]);
                    ai = ((f < 0) ? -f : f) & 32'hFFFF;
                    aq = ((g < 0) ? -g : g) & 32'hFFFF;
                    e  = int'(m_ema[b]);
                    e  = e - (e >> SMOOTH_T) + ((ai + aq) >> SMOOTH_T);
                    m_ema[b] = e[17:0];
                    f  = f - (f >>> STRIPE_T) + int'(m_imix[b]);
                    g  = g - (g >>> STRIPE_T) + int'(m_qmix[b]);
                    m_ifilt[b] = f[15:0];
                    m_qfilt[b] = g[15:0];
                    m_imix[b]  = ref_value(m_sample, m_phase[b]);
                    m_qmix[b]  = ref_value(m_sample, m_phase[b] + 5'd8);
                    m_phase[b] = m_phase[b] + 5'd1;
                end
                m_step[b] = (m_cnt[b] == count_t'(m_counts[b] - 1'b1));
                m_cnt[b]  = m_step[b] ? '0 : m_cnt[b] + 1'b1;
                if (cfg_we && cfg_addr == band_idx_t'(b)) begin
                    m_counts[b] = (cfg_wdata == '0) ? count_t'(1) : cfg_wdata;
                end
            end
            if (sample_valid) begin
                m_sample = sample_in;
            end
        end
    end

    task automatic report_fail(input string what, input int got, input int exp);
        $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "mismatch");
    endtask

    task automatic check_level(input level_t got, input level_t exp, input string what);
        if (got !== exp) report_fail(what, int'(got), int'(exp));
    endtask

    task automatic check_band(input band_idx_t got, input band_idx_t exp, input string what);
        if (got !== exp) report_fail(what, int'(got), int'(exp));
    endtask

    task automatic check_count(input count_t got, input count_t exp, input string what);
        if (got !== exp) report_fail(what, int'(got), int'(exp));
    endtask

    task automatic check_outputs();
        for (int b = 0; b < NB; b++) begin
            check_level(levels[b], m_level[b], $sformatf("level of band %0d", b));
        end
        check_band(peak_band, m_pband, "peak band");
        check_level(peak_level, m_plevel, "peak level");
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int b = 0; b < NB; b++) begin
            check_level(levels[b], '0, "level after reset");
        end
        check_band(peak_band, '0, "peak band after reset");
        check_level(peak_level, '0, "peak level after reset");
    endtask

    task automatic cfg_write(input int addr, input int data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= band_idx_t'(addr);
        cfg_wdata <= count_t'(data);
        @(posedge clk);
        cfg_we <= 1'b0;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic cfg_read(input int addr, input int exp);
        @(posedge clk);
        cfg_addr <= band_idx_t'(addr);
        @(negedge clk);
        check_count(cfg_rdata, count_t'(exp), $sformatf("read of address %0d", addr));
    endtask

    task automatic run_row(input row_t r);
        int tone;
        apply_reset();
        for (int b = 0; b < NB; b++) begin
            cfg_write(b, r.counts[b]);
        end
        for (int i = 0; i < r.run; i++) begin
            tone = ((i % r.period) < r.period / 2) ? r.amp : -r.amp;
            if (r.noise) begin
                tone = tone + int'($urandom % 128) - 64;
            end
            @(posedge clk);
            sample_in    <= sample_t'(tone);
            sample_valid <= r.noise ? ($urandom % 4 != 0) : 1'b1;
            @(negedge clk);
            check_outputs();
        end
        if (r.exp_band >= 0) begin
            check_band(peak_band, band_idx_t'(r.exp_band), "expected peak band");
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'h2995c5a5));
        rst          = 1'b1;
        sample_in    = '0;
        sample_valid = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        cycles       = 0;
        rows[0] = '{'{1, 2, 3, 4}, 32, 0, 1'b0, 300, 0};
        rows[1] = '{'{1, 3, 4, 6}, 32, 300, 1'b0, 1500, 0};
        rows[2] = '{'{3, 4, 6, 1}, 32, 300, 1'b0, 1500, 3};
        rows[3] = '{'{6, 1, 3, 4}, 32, 300, 1'b0, 1500, 1};
        rows[4] = '{'{2, 5, 1, 3}, 64, 250, 1'b1, 1500, -1};
        limit = 200;
        for (int r = 0; r < NROWS; r++) begin
            limit += rows[r].run;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // configuration writes and read-back
        cfg_write(0, 5);
        cfg_write(1, 0);
        cfg_write(2, 100);
        cfg_write(3, 7);
        cfg_write(9, 3);
        cfg_read(0, 5);
        cfg_read(1, 1);
        cfg_read(2, 100);
        cfg_read(3, 7);
        cfg_read(9, 0);
        cfg_read(4, 0);

        for (int r = 0; r < NROWS; r++) begin
            run_row(rows[r]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/band_pkg.sv
rtl/tap_scaler.sv
rtl/band_detector.sv
rtl/band_config.sv
rtl/band_peak_finder.sv
rtl/band_meter_top.sv
sim/band_meter_props.sv
sim/band_meter_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= band_meter_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
